// ==== hw/spr_consts.svh ====
`ifndef SPR_CONSTS_SVH
`define SPR_CONSTS_SVH

// sprite descriptors held in the table
`define SPR_COUNT 32

// visible pixels of one TV line
`define SPR_LINE_PIX 360

// line buffer address width, 512 locations per half
`define SPR_XW 9

// DRAM word address width, 2M words of 16 bits
`define SPR_AW 21

// per-sprite bitmap offset in words
`define SPR_OFFW 14

`endif

// ==== hw/spr_types_pkg.sv ====
package spr_types_pkg;

`include "spr_consts.svh"

	// one descriptor after the 8 bytes are gathered
	typedef struct packed {
		logic                  act;   // sprite enabled
		logic [3:0]            pal;   // palette bank, upper half of palette address
		logic [`SPR_AW-1:0]    base;  // word address of the bitmap
		logic [`SPR_XW-1:0]    xpos;
		logic [6:0]            xsz;   // width in 16-bit words
		logic [8:0]            ypos;
		logic [6:0]            ysz;   // height in lines
	} spr_desc_t;

	// engine FSM
	typedef enum logic [3:0] {
		S_IDLE,   // waiting for spr_en after line_start
		S_DESC,   // gathering descriptor bytes
		S_CHECK,  // visibility test against the next line
		S_OFFS,   // offset fetch or restart
		S_REQ,    // raise DRAM request
		S_WAIT,   // hold request until drdy
		S_PIX,    // four pixels through the palette
		S_NEXT,   // step to next sprite
		S_DONE    // all sprites done for this line
	} spr_state_e;

endpackage

// ==== hw/spr_bus_pkg.sv ====
package spr_bus_pkg;

`include "spr_consts.svh"

	// config port write, addr[8] picks palette over descriptor bytes
	typedef struct packed {
		logic       we;
		logic [8:0] addr;
		logic [7:0] data;
	} cfg_wr_t;

	// DRAM request, mrq held until drdy
	typedef struct packed {
		logic               mrq;
		logic [`SPR_AW-1:0] addr;
	} mem_req_t;

	// one pixel into the line buffer half being built
	typedef struct packed {
		logic               we;
		logic [`SPR_XW-1:0] x;
		logic               opaque;  // nibble was non-zero
		logic [5:0]         color;
	} lb_wr_t;

endpackage

// ==== hw/spr_regs.sv ====
`timescale 1ns/1ns

`include "spr_consts.svh"

module spr_regs
	import spr_bus_pkg::*;
(
	input  logic       clk,
	input  cfg_wr_t    cfg,
	input  logic [4:0] desc_idx,
	input  logic [2:0] desc_byte,
	output logic [7:0] desc_rd,
	input  logic [7:0] pal_addr,
	output logic [5:0] pal_rd
);

	localparam int DESC_BYTES = `SPR_COUNT * 8;

	// 8 bytes per sprite, sprite n at bytes 8n..8n+7
	logic [7:0] desc_mem [DESC_BYTES];
	// 16 banks of 16 colours, 6 bits each
	logic [5:0] pal_mem [256];

	logic pal_sel;   // config write goes to the palette
	logic desc_we;
	logic pal_we;

	assign pal_sel = cfg.addr[8];
	assign desc_we = cfg.we & ~pal_sel;
	assign pal_we  = cfg.we & pal_sel;

	// descriptor table
	always_ff @(posedge clk)
	begin
		if (desc_we)
			desc_mem[cfg.addr[7:0]] <= cfg.data;
		desc_rd <= desc_mem[{desc_idx, desc_byte}];   // one cycle read for the engine
	end

	// palette
	always_ff @(posedge clk)
	begin
		if (pal_we)
			pal_mem[cfg.addr[7:0]] <= cfg.data[5:0];   // top two bits dropped
		pal_rd <= pal_mem[pal_addr];   // addressed by {bank, nibble}
	end

endmodule

// ==== hw/spr_offs_ram.sv ====
`timescale 1ns/1ns

`include "spr_consts.svh"

module spr_offs_ram
(
	input  logic                 clk,
	input  logic [4:0]           ra,
	output logic [`SPR_OFFW-1:0] rd,
	input  logic [4:0]           wa,
	input  logic [`SPR_OFFW-1:0] wd,
	input  logic                 we
);

	// word offset into each sprite bitmap, kept from line to line
	logic [`SPR_OFFW-1:0] offs_mem [`SPR_COUNT];

	always_ff @(posedge clk)
	begin
		if (we)
			offs_mem[wa] <= wd;   // written once per drawn sprite
		rd <= offs_mem[ra];       // registered read
	end

endmodule

// ==== hw/spr_engine.sv ====
`timescale 1ns/1ns

`include "spr_consts.svh"

module spr_engine
	import spr_types_pkg::*;
	import spr_bus_pkg::*;
(
	input  logic                 clk,
	input  logic                 line_start,
	input  logic                 spr_en,
	input  logic [8:0]           line_num,
	output logic [4:0]           desc_idx,
	output logic [2:0]           desc_byte,
	input  logic [7:0]           desc_rd,
	output logic [7:0]           pal_addr,
	input  logic [5:0]           pal_rd,
	output logic [4:0]           offs_ra,
	input  logic [`SPR_OFFW-1:0] offs_rd,
	output logic [4:0]           offs_wa,
	output logic [`SPR_OFFW-1:0] offs_wd,
	output logic                 offs_we,
	output mem_req_t             mem,
	input  logic [15:0]          mem_dat,
	input  logic                 mem_drdy,
	output lb_wr_t               lb_wr,
	output logic                 spr_busy
);

	spr_state_e state;
	logic [4:0] sp_num;         // sprite being worked on
	logic [3:0] cnt;            // byte count in S_DESC, pixel phase in S_PIX
	logic [63:0] desc_raw;      // gathered bytes, byte 0 in the low bits
	spr_desc_t desc;
	logic [8:0] tgt_line;       // line being built
	logic [9:0] y_end;          // first line below the sprite
	logic hit;
	logic first_line;
	logic last_word;

	logic [`SPR_OFFW-1:0] offset;   // running word offset into bitmap
	logic [6:0] wcnt;               // words left in this row
	logic [`SPR_XW-1:0] x;          // next pixel position
	logic [15:0] dat_sh;            // fetched word, shifted one nibble per pixel
	logic [3:0] nib_q;              // nibble whose colour arrives this cycle

	logic mrq_q;
	logic [`SPR_AW-1:0] addr_q;
	logic lb_we;
	logic [`SPR_XW-1:0] lb_x;
	logic lb_opq;
	logic [5:0] lb_col;

	// byte layout straight from the descriptor table
	assign desc = '{
		act:  desc_raw[7],
		pal:  desc_raw[3:0],
		base: desc_raw[8 +: `SPR_AW],
		xpos: desc_raw[32 +: `SPR_XW],
		xsz:  desc_raw[47:41],
		ypos: desc_raw[56:48],
		ysz:  desc_raw[63:57]
	};

	assign tgt_line   = line_num + 9'd1;   // work is one line ahead of display
	assign y_end      = {1'b0, desc.ypos} + {3'b0, desc.ysz};
	assign first_line = (tgt_line == desc.ypos);
	assign last_word  = (wcnt == 7'd1);

	// skip inactive, zero width and sprites off this line
	assign hit = desc.act && (desc.xsz != 7'd0) && (tgt_line >= desc.ypos) &&
		({1'b0, tgt_line} < y_end);

	assign desc_idx  = sp_num;
	assign desc_byte = cnt[2:0];
	assign offs_ra   = sp_num;      // read is ready long before S_OFFS
	assign offs_wa   = sp_num;
	assign offs_wd   = offset;      // already advanced by xsz in S_NEXT
	assign pal_addr  = {desc.pal, dat_sh[15:12]};   // msb nibble first

	assign mem   = '{mrq: mrq_q, addr: addr_q};
	assign lb_wr = '{we: lb_we, x: lb_x, opaque: lb_opq, color: lb_col};

	assign spr_busy = (state != S_IDLE) && (state != S_DONE);

	// control
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state   <= S_IDLE;
			sp_num  <= '0;
			cnt     <= '0;
			mrq_q   <= 1'b0;
			lb_we   <= 1'b0;
			offs_we <= 1'b0;
		end
		else
		begin
			lb_we   <= 1'b0;   // both are single cycle strobes
			offs_we <= 1'b0;
			case (state)
				S_IDLE:
					if (spr_en)
					begin
						sp_num <= '0;
						cnt    <= '0;
						state  <= S_DESC;
					end
				S_DESC:
				begin
					cnt <= cnt + 4'd1;
					if (cnt == 4'd8)   // byte 7 on desc_rd now
						state <= S_CHECK;
				end
				S_CHECK:
					state <= hit ? S_OFFS : S_NEXT;
				S_OFFS:
					state <= S_REQ;
				S_REQ:
				begin
					mrq_q <= 1'b1;
					state <= S_WAIT;
				end
				S_WAIT:
					if (mem_drdy)   // no timeout, waits as long as DRAM needs
					begin
						mrq_q <= 1'b0;
						cnt   <= '0;
						state <= S_PIX;
					end
				S_PIX:
				begin
					cnt <= cnt + 4'd1;
					if (cnt != 4'd0)
						lb_we <= (x < `SPR_LINE_PIX);   // nothing past the visible line
					if (cnt == 4'd4)
					begin
						if (last_word)
						begin
							offs_we <= 1'b1;
							state   <= S_NEXT;
						end
						else
							state <= S_REQ;
					end
				end
				S_NEXT:
				begin
					sp_num <= sp_num + 5'd1;
					cnt    <= '0;
					state  <= (sp_num == 5'(`SPR_COUNT - 1)) ? S_DONE : S_DESC;
				end
				S_DONE: ;   // stays here until next line_start
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk)
	begin
		case (state)
			S_DESC:
				if (cnt != 4'd0)
					desc_raw <= {desc_rd, desc_raw[63:8]};
			S_OFFS:
			begin
				offset <= first_line ? '0 : offs_rd;   // restart bitmap on top line
				wcnt   <= desc.xsz;
				x      <= desc.xpos;
			end
			S_REQ:
				addr_q <= desc.base + {{(`SPR_AW - `SPR_OFFW){1'b0}}, offset};
			S_WAIT:
				if (mem_drdy)
					dat_sh <= mem_dat;
			S_PIX:
			begin
				// lookup of nibble cnt overlaps write of nibble cnt-1
				if (cnt < 4'd4)
				begin
					nib_q  <= dat_sh[15:12];
					dat_sh <= {dat_sh[11:0], 4'h0};
				end
				if (cnt != 4'd0)
				begin
					lb_x   <= x;
					lb_opq <= (nib_q != 4'h0);   // colour 0 is see-through
					lb_col <= pal_rd;
					x      <= x + 1'b1;
				end
				if (cnt == 4'd4)
				begin
					offset <= offset + 1'b1;
					wcnt   <= wcnt - 7'd1;
				end
			end
			default: ;
		endcase
	end

endmodule

// ==== hw/spr_line_buf.sv ====
`timescale 1ns/1ns

`include "spr_consts.svh"

module spr_line_buf
	import spr_bus_pkg::*;
(
	input  logic       clk,
	input  logic       line_start,
	input  logic       pre_cend,
	input  logic       disp_sel,
	input  lb_wr_t     lb_wr,
	output logic [5:0] spixel,
	output logic       spx_en
);

	localparam int LB_DEPTH = 1 << `SPR_XW;

	// two halves of {valid, colour}, disp_sel picks the one on screen
	logic [6:0] lb_mem [2][LB_DEPTH];
	logic [`SPR_XW-1:0] rd_x;   // readout position
	logic lb_we;

	// transparent pixels never land, so earlier sprites show through
	assign lb_we = lb_wr.we & lb_wr.opaque;

	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
			rd_x <= '0;
		else if (pre_cend)
			rd_x <= rd_x + 1'b1;
	end

	for (genvar h = 0; h < 2; h++)
	begin : g_half
		always_ff @(posedge clk)
		begin
			if (disp_sel == 1'(h))
			begin
				if (pre_cend)
					lb_mem[h][rd_x] <= '0;   // wipe behind the beam for reuse
			end
			else if (lb_we)
				lb_mem[h][lb_wr.x] <= {1'b1, lb_wr.color};   // later sprite wins
		end
	end

	// pixel out one cycle after the strobe
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			spx_en <= 1'b0;
			spixel <= '0;
		end
		else if (pre_cend)
			{spx_en, spixel} <= lb_mem[disp_sel][rd_x];
	end

endmodule

// ==== hw/sprite_unit.sv ====
`timescale 1ns/1ns

`include "spr_consts.svh"

module sprite_unit
	import spr_bus_pkg::*;
(
	input  logic        clk,
	input  logic        line_start,   // also restarts the engine each line
	input  logic        spr_en,
	input  logic [8:0]  line_num,
	input  logic        pre_cend,
	input  cfg_wr_t     cfg,
	output mem_req_t    mem,
	input  logic [15:0] mem_dat,
	input  logic        mem_drdy,
	output logic [5:0]  spixel,
	output logic        spx_en,
	output logic        spr_busy
);

	logic [4:0] desc_idx;
	logic [2:0] desc_byte;
	logic [7:0] desc_rd;
	logic [7:0] pal_addr;
	logic [5:0] pal_rd;
	logic [4:0] offs_ra;
	logic [4:0] offs_wa;
	logic [`SPR_OFFW-1:0] offs_rd;
	logic [`SPR_OFFW-1:0] offs_wd;
	logic offs_we;
	lb_wr_t lb_wr;

	spr_regs u_regs (
		.clk       (clk),
		.cfg       (cfg),
		.desc_idx  (desc_idx),
		.desc_byte (desc_byte),
		.desc_rd   (desc_rd),
		.pal_addr  (pal_addr),
		.pal_rd    (pal_rd)
	);

	spr_offs_ram u_offs_ram (
		.clk (clk),
		.ra  (offs_ra),
		.rd  (offs_rd),
		.wa  (offs_wa),
		.wd  (offs_wd),
		.we  (offs_we)
	);

	spr_engine u_engine (
		.clk        (clk),
		.line_start (line_start),
		.spr_en     (spr_en),
		.line_num   (line_num),
		.desc_idx   (desc_idx),
		.desc_byte  (desc_byte),
		.desc_rd    (desc_rd),
		.pal_addr   (pal_addr),
		.pal_rd     (pal_rd),
		.offs_ra    (offs_ra),
		.offs_rd    (offs_rd),
		.offs_wa    (offs_wa),
		.offs_wd    (offs_wd),
		.offs_we    (offs_we),
		.mem        (mem),
		.mem_dat    (mem_dat),
		.mem_drdy   (mem_drdy),
		.lb_wr      (lb_wr),
		.spr_busy   (spr_busy)
	);

	// odd lines show half 1, the engine fills the other one
	spr_line_buf u_line_buf (
		.clk        (clk),
		.line_start (line_start),
		.pre_cend   (pre_cend),
		.disp_sel   (line_num[0]),
		.lb_wr      (lb_wr),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

endmodule

// ==== verif/sprite_unit_asserts.sv ====
`timescale 1ns/1ns

module sprite_unit_asserts
	import spr_bus_pkg::*;
(
	input logic     clk,
	input logic     line_start,
	input mem_req_t mem,
	input logic     mem_drdy,
	input lb_wr_t   lb_wr,
	input logic     spr_busy
);

	// request stays up with a steady address until drdy
	a_mrq_hold: assert property (@(posedge clk) disable iff (line_start)
		mem.mrq && !mem_drdy |=> mem.mrq && $stable(mem.addr))
		else $error("DRAM request dropped or address moved before drdy");

	// one cycle of low mrq after each answer
	a_mrq_drop: assert property (@(posedge clk) disable iff (line_start)
		mem.mrq && mem_drdy |=> !mem.mrq)
		else $error("DRAM request still high after drdy");

	a_mrq_addr: assert property (@(posedge clk) disable iff (line_start)
		$rose(mem.mrq) |-> !$isunknown(mem.addr))
		else $error("DRAM request raised with unknown address");

	// engine is quiet once the line is done
	a_req_busy: assert property (@(posedge clk) disable iff (line_start)
		mem.mrq |-> spr_busy)
		else $error("DRAM request while spr_busy low");

	a_wr_busy: assert property (@(posedge clk) disable iff (line_start)
		lb_wr.we |-> spr_busy)
		else $error("line buffer write while spr_busy low");

endmodule

bind spr_engine sprite_unit_asserts u_asserts (
	.clk        (clk),
	.line_start (line_start),
	.mem        (mem),
	.mem_drdy   (mem_drdy),
	.lb_wr      (lb_wr),
	.spr_busy   (spr_busy)
);

// ==== verif/tb_sprite_unit.sv ====
`timescale 1ns/1ns

`include "spr_consts.svh"

module tb_sprite_unit
	import spr_bus_pkg::*;
();

	localparam logic [31:0] SEED = 32'he787_27bf;
	localparam int N_LINES = 41;
	localparam int BUSY_LIMIT = 20000;   // far above the worst case line

	logic clk;
	logic line_start;
	logic spr_en;
	logic [8:0] line_num;
	logic pre_cend;
	cfg_wr_t cfg;
	mem_req_t mem;
	logic [15:0] mem_dat;
	logic mem_drdy;
	logic [5:0] spixel;
	logic spx_en;
	logic spr_busy;

	logic [31:0] rng;
	int n_checks;
	int n_errors;
	bit timed_out;

	// reference model
	logic [5:0] pal_m [256];
	logic d_act [`SPR_COUNT];
	logic [3:0] d_pal [`SPR_COUNT];
	logic [20:0] d_base [`SPR_COUNT];
	logic [8:0] d_xpos [`SPR_COUNT];
	logic [6:0] d_xsz [`SPR_COUNT];
	logic [8:0] d_ypos [`SPR_COUNT];
	logic [6:0] d_ysz [`SPR_COUNT];
	logic [13:0] offs_m [`SPR_COUNT];       // words consumed per sprite
	logic [6:0] exp_cur [`SPR_LINE_PIX];    // {valid, colour} on screen now
	logic [6:0] exp_next [`SPR_LINE_PIX];   // built for the following line

	sprite_unit u_sprite_unit (
		.clk        (clk),
		.line_start (line_start),
		.spr_en     (spr_en),
		.line_num   (line_num),
		.pre_cend   (pre_cend),
		.cfg        (cfg),
		.mem        (mem),
		.mem_dat    (mem_dat),
		.mem_drdy   (mem_drdy),
		.spixel     (spixel),
		.spx_en     (spx_en),
		.spr_busy   (spr_busy)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] next_rand();
		rng = lcg_step(rng);
		return rng;
	endfunction

	// bitmap word held at each DRAM address
	function automatic logic [15:0] dram_word(input logic [20:0] a);
		logic [31:0] h;
		h = lcg_step({11'd0, a} ^ SEED);
		return h[31:16];
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic write_cfg(input logic [8:0] a, input logic [7:0] d);
		@(negedge clk);
		cfg = '{we: 1'b1, addr: a, data: d};
	endtask

	// random palette and descriptor table, mirrored into the model
	task automatic load_config();
		logic [7:0] b [8];
		logic [7:0] r;
		for (int i = 0; i < 256; i++)
		begin
			r = 8'(next_rand() >> 24);
			pal_m[i] = r[5:0];   // top bits not stored
			write_cfg(9'h100 | 9'(i), r);
		end
		for (int s = 0; s < `SPR_COUNT; s++)
		begin
			r = 8'(next_rand() >> 24);
			d_act[s] = (r[7:6] != 2'b00);   // about three in four active
			d_pal[s] = r[3:0];
			d_base[s] = 21'(next_rand() >> 11);
			d_xpos[s] = 9'((next_rand() >> 16) % 380);    // some run past pixel 359
			d_xsz[s] = 7'((next_rand() >> 16) % 5);       // zero width now and then
			d_ypos[s] = 9'(2 + (next_rand() >> 16) % 19);
			d_ysz[s] = 7'((next_rand() >> 16) % 8);
			b[0] = {d_act[s], r[6:4], d_pal[s]};          // middle bits unused
			b[1] = d_base[s][7:0];
			b[2] = d_base[s][15:8];
			b[3] = {r[2:0], d_base[s][20:16]};
			b[4] = d_xpos[s][7:0];
			b[5] = {d_xsz[s], d_xpos[s][8]};
			b[6] = d_ypos[s][7:0];
			b[7] = {d_ysz[s], d_ypos[s][8]};
			for (int k = 0; k < 8; k++)
				write_cfg(9'(s * 8 + k), b[k]);
		end
		@(negedge clk);
		cfg.we = 1'b0;
	endtask

	task automatic start_line(input int num, input logic en);
		@(negedge clk);
		line_num = 9'(num);
		line_start = 1'b1;
		spr_en = en;
		@(negedge clk);
		check_eq({29'd0, mem.mrq, spr_busy, spx_en}, 32'd0, "outputs low in line_start");
		line_start = 1'b0;
	endtask

	task automatic wait_done(input int num);
		int cyc;
		cyc = 0;
		while (spr_busy === 1'b1 && cyc < BUSY_LIMIT)
		begin
			@(negedge clk);
			cyc++;
		end
		if (spr_busy !== 1'b0)
		begin
			timed_out = 1'b1;
			n_errors++;
			$display("Timeout: spr_busy still high %0d cycles into line %0d", cyc, num);
		end
	endtask

	// restart the engine at its first DRAM request while nothing is written yet
	task automatic restart_at_request(input int num);
		int cyc;
		cyc = 0;
		while (mem.mrq !== 1'b1 && spr_busy === 1'b1 && cyc < BUSY_LIMIT)
		begin
			@(negedge clk);
			cyc++;
		end
		if (mem.mrq === 1'b1)
			start_line(num, 1'b1);   // rerun rebuilds the same line from sprite 0
	endtask

	// what the engine should build during line num
	task automatic build_next(input int num);
		logic [8:0] tgt;
		logic [13:0] off;
		logic [15:0] w;
		logic [3:0] nib;
		logic [8:0] px;
		tgt = 9'(num + 1);
		for (int x = 0; x < `SPR_LINE_PIX; x++)
			exp_next[x] = '0;
		for (int s = 0; s < `SPR_COUNT; s++)
			if (d_act[s] && d_xsz[s] != 7'd0 && tgt >= d_ypos[s] &&
				10'(tgt) < 10'(d_ypos[s]) + 10'(d_ysz[s]))
			begin
				off = (tgt == d_ypos[s]) ? 14'd0 : offs_m[s];   // top row restarts bitmap
				for (int k = 0; k < d_xsz[s]; k++)
				begin
					w = dram_word(d_base[s] + 21'(off));
					for (int n = 0; n < 4; n++)
					begin
						nib = w[15 - 4 * n -: 4];   // msb nibble is leftmost
						px = d_xpos[s] + 9'(4 * k + n);
						if (px < `SPR_LINE_PIX && nib != 4'h0)
							exp_next[px] = {1'b1, pal_m[{d_pal[s], nib}]};
					end
					off = off + 14'd1;
				end
				offs_m[s] = off;
			end
	endtask

	// strobe out the shown half, pixel one cycle after each strobe
	task automatic read_line(input int num, input bit check);
		for (int x = 0; x < `SPR_LINE_PIX; x++)
		begin
			@(negedge clk);
			pre_cend = 1'b1;
			@(negedge clk);
			pre_cend = 1'b0;
			if (check)
				check_eq({25'd0, spx_en, spixel}, {25'd0, exp_cur[x]},
					$sformatf("line %0d pixel %0d", num, x));
		end
	endtask

	// DRAM answers after 1 to 5 cycles
	always
	begin : dram_responder
		int delay;
		@(negedge clk);
		if (mem.mrq === 1'b1)
		begin
			delay = 1 + int'((next_rand() >> 16) % 5);
			repeat (delay - 1) @(negedge clk);
			mem_dat = dram_word(mem.addr);
			mem_drdy = 1'b1;
			@(negedge clk);
			mem_drdy = 1'b0;
		end
	end

	initial
	begin
		rng = SEED;
		clk = 1'b0;
		line_start = 1'b1;
		spr_en = 1'b0;
		line_num = '0;
		pre_cend = 1'b0;
		cfg = '0;
		mem_dat = '0;
		mem_drdy = 1'b0;
		n_checks = 0;
		n_errors = 0;
		timed_out = 1'b0;
		for (int x = 0; x < `SPR_LINE_PIX; x++)
			exp_cur[x] = '0;
		repeat (4) @(negedge clk);
		line_start = 1'b0;
		load_config();
		start_line(0, 1'b0);   // readout wipes both halves, engine off
		read_line(0, 1'b0);
		start_line(1, 1'b0);
		read_line(1, 1'b0);
		for (int l = 0; l < N_LINES && !timed_out; l++)
		begin
			start_line(l, 1'b1);
			@(negedge clk);
			check_eq(32'(spr_busy), 32'd1, "spr_busy one cycle after line_start");
			if (l % 4 == 3)
				restart_at_request(l);   // line_start lands on a live request
			wait_done(l);
			build_next(l);
			read_line(l, 1'b1);
			exp_cur = exp_next;
		end
		$display("checks: %0d  errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+hw
hw/spr_types_pkg.sv
hw/spr_bus_pkg.sv
hw/spr_regs.sv
hw/spr_offs_ram.sv
hw/spr_engine.sv
hw/spr_line_buf.sv
hw/sprite_unit.sv
verif/sprite_unit_asserts.sv
verif/tb_sprite_unit.sv
